// File: filelist.f
+incdir+logic
logic/bringup_pkg.sv
logic/bringup_timebase.sv
logic/bringup_sensor_bank.sv
logic/uart_tx.sv
logic/bringup_scanner.sv
logic/bringup_boundary.sv
tb/tb_bringup.sv

// File: logic/bringup_boundary.sv
// bringup top level, drives tp9 and reports pin activity over the uart
`include "bringup_consts.svh"

module bringup_boundary #(
	parameter int CLOCKS_PER_BAUD = `BRINGUP_CLOCKS_PER_BAUD,
	parameter int CLOCKS_PER_SCAN = `BRINGUP_CLOCKS_PER_SCAN,
	parameter int CLOCKS_PER_DRIVE = `BRINGUP_CLOCKS_PER_DRIVE
) (
	input  logic clock,
	input  logic reset_i,
	input  bringup_pkg::pin_vec_t pins_i,
	output logic tp9_o,
	output logic uart_tx_o
);

import bringup_pkg::*;

logic scan_pulse;
pin_vec_t sensed;
logic clear;
logic uart_write;
logic [7:0] uart_data;
logic uart_busy;

bringup_timebase #(
	.CLOCKS_PER_SCAN(CLOCKS_PER_SCAN),
	.CLOCKS_PER_DRIVE(CLOCKS_PER_DRIVE)
) bringup_timebase0(
	.clock(clock),
	.reset_i(reset_i),
	.scan_pulse_o(scan_pulse),
	.drive_o(tp9_o)); // known toggling pin

bringup_sensor_bank bringup_sensor_bank0(
	.clock(clock),
	.reset_i(reset_i),
	.pins_i(pins_i),
	.clear_i(clear),
	.sensed_o(sensed));

bringup_scanner bringup_scanner0(
	.clock(clock),
	.reset_i(reset_i),
	.pulse_i(scan_pulse),
	.state_i(sensed),
	.hold_i(uart_busy),
	.clear_o(clear),
	.write_o(uart_write),
	.data_o(uart_data));

uart_tx #(
	.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD)
) uart_tx0(
	.clock(clock),
	.reset_i(reset_i),
	.write_i(uart_write),
	.data_i(uart_data),
	.busy_o(uart_busy),
	.tx_o(uart_tx_o));

endmodule

// File: logic/bringup_consts.svh
// bringup constants: pin count, default clock divisions and report characters
`ifndef BRINGUP_CONSTS_SVH
`define BRINGUP_CONSTS_SVH

// sensed pins in the report
`define BRINGUP_PINS 16

// 115200 baud at 12 MHz
`define BRINGUP_CLOCKS_PER_BAUD 104

// 10 Hz scan rate
`define BRINGUP_CLOCKS_PER_SCAN 1200000

// half period of the drive pin
`define BRINGUP_CLOCKS_PER_DRIVE 6000

// report bytes, ascii
`define BRINGUP_CHAR_ACTIVE 8'h31
`define BRINGUP_CHAR_QUIET 8'h30
`define BRINGUP_CHAR_CR 8'h0d
`define BRINGUP_CHAR_LF 8'h0a

`endif

// File: logic/bringup_pkg.sv
// bringup package, pin vector type and the scanner and UART state encodings
`include "bringup_consts.svh"

package bringup_pkg;

	// one bit per sensed pin, pin 0 at bit 0
	typedef logic [`BRINGUP_PINS-1:0] pin_vec_t;

	// report scanner
	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_SEND, // byte ready, waiting for the uart to be free
		SCAN_WAIT  // byte in flight
	} scan_state_t;

	// 8N1 transmitter
	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

endpackage

// File: logic/bringup_scanner.sv
// bringup scanner, snapshots the activity flags on each scan pulse and sends a text report
`include "bringup_consts.svh"

module bringup_scanner(
	input  logic clock,
	input  logic reset_i,
	input  logic pulse_i,
	input  bringup_pkg::pin_vec_t state_i,
	input  logic hold_i,
	output logic clear_o,
	output logic write_o,
	output logic [7:0] data_o
);

import bringup_pkg::*;

// one character per pin, then CR LF
localparam int REPORT_LEN = `BRINGUP_PINS + 2;
localparam int IDX_W = $clog2(REPORT_LEN + 1);
localparam int PIN_W = $clog2(`BRINGUP_PINS);

scan_state_t state;
pin_vec_t snapshot;
logic [IDX_W-1:0] index;
logic take;

// pulses outside idle are dropped
assign take = (state == SCAN_IDLE) && pulse_i;

// flags are cleared on the same edge that captures them
assign clear_o = take;
assign write_o = (state == SCAN_SEND) && !hold_i;

always_comb begin
	if (index < IDX_W'(`BRINGUP_PINS)) begin
		if (snapshot[index[PIN_W-1:0]])
			data_o = `BRINGUP_CHAR_ACTIVE;
		else
			data_o = `BRINGUP_CHAR_QUIET;
	end else if (index == IDX_W'(`BRINGUP_PINS)) begin
		data_o = `BRINGUP_CHAR_CR;
	end else begin
		data_o = `BRINGUP_CHAR_LF;
	end
end

always_ff @(posedge clock) begin
	if (take)
		snapshot <= state_i;
end

always_ff @(posedge clock) begin
	if (reset_i) begin
		state <= SCAN_IDLE;
		index <= '0;
	end else begin
		case (state)
		SCAN_IDLE: begin
			if (pulse_i) begin
				state <= SCAN_SEND;
				index <= '0;
			end
		end
		SCAN_SEND: begin
			if (!hold_i) begin // byte goes out this cycle
				state <= SCAN_WAIT;
				index <= index + 1'b1;
			end
		end
		SCAN_WAIT: begin
			// busy rises right after the write, so this waits out the frame
			if (!hold_i) begin
				if (index == IDX_W'(REPORT_LEN))
					state <= SCAN_IDLE;
				else
					state <= SCAN_SEND;
			end
		end
		default: state <= SCAN_IDLE;
		endcase
	end
end

endmodule

// File: logic/bringup_sensor_bank.sv
// bringup sensor bank, synchronizes each pin and holds a sticky flag on any edge
module bringup_sensor_bank(
	input  logic clock,
	input  logic reset_i,
	input  bringup_pkg::pin_vec_t pins_i,
	input  logic clear_i,
	output bringup_pkg::pin_vec_t sensed_o
);

import bringup_pkg::*;

for (genvar i = 0; i < $bits(pin_vec_t); i++) begin : g_pin
	logic sync1;
	logic sync2;
	logic last;
	logic pin_edge;
	logic flag;

	// two flop synchronizer plus the previous level
	always_ff @(posedge clock) begin
		sync1 <= pins_i[i];
		sync2 <= sync1;
		last <= sync2;
	end

	assign pin_edge = sync2 ^ last; // rise or fall

	always_ff @(posedge clock) begin
		if (reset_i)
			flag <= 1'b0;
		else if (pin_edge)
			flag <= 1'b1; // a fresh edge wins over clear
		else if (clear_i)
			flag <= 1'b0;
	end

	assign sensed_o[i] = flag;
end

endmodule

// File: logic/bringup_timebase.sv
// bringup timebase, makes the periodic scan strobe and the square wave on the drive pin
`include "bringup_consts.svh"

module bringup_timebase #(
	parameter int CLOCKS_PER_SCAN = `BRINGUP_CLOCKS_PER_SCAN,
	parameter int CLOCKS_PER_DRIVE = `BRINGUP_CLOCKS_PER_DRIVE
) (
	input  logic clock,
	input  logic reset_i,
	output logic scan_pulse_o,
	output logic drive_o
);

localparam int SCAN_W = $clog2(CLOCKS_PER_SCAN);
localparam int DRIVE_W = $clog2(CLOCKS_PER_DRIVE);

logic [SCAN_W-1:0] scan_count;
logic [DRIVE_W-1:0] drive_count;
logic scan_wrap;
logic drive_wrap;

assign scan_wrap = (scan_count == SCAN_W'(CLOCKS_PER_SCAN - 1));
assign drive_wrap = (drive_count == DRIVE_W'(CLOCKS_PER_DRIVE - 1));

// scan strobe, one cycle per period
always_ff @(posedge clock) begin
	if (reset_i) begin
		scan_count <= '0;
		scan_pulse_o <= 1'b0;
	end else begin
		scan_pulse_o <= scan_wrap;
		if (scan_wrap)
			scan_count <= '0;
		else
			scan_count <= scan_count + 1'b1;
	end
end

always_ff @(posedge clock) begin
	if (reset_i) begin
		drive_count <= '0;
		drive_o <= 1'b0; // tp9 starts low
	end else begin
		if (drive_wrap) begin
			drive_count <= '0;
			drive_o <= ~drive_o;
		end else begin
			drive_count <= drive_count + 1'b1;
		end
	end
end

endmodule

// File: logic/uart_tx.sv
// uart transmitter, sends one 8N1 frame per write and holds busy until the stop bit ends
`include "bringup_consts.svh"

module uart_tx #(
	parameter int CLOCKS_PER_BAUD = `BRINGUP_CLOCKS_PER_BAUD
) (
	input  logic clock,
	input  logic reset_i,
	input  logic write_i,
	input  logic [7:0] data_i,
	output logic busy_o,
	output logic tx_o
);

import bringup_pkg::*;

localparam int BAUD_W = $clog2(CLOCKS_PER_BAUD);

tx_state_t state;
logic [BAUD_W-1:0] baud_count;
logic [2:0] bit_count;
logic [7:0] shift;
logic baud_wrap;

assign baud_wrap = (baud_count == BAUD_W'(CLOCKS_PER_BAUD - 1));
assign busy_o = (state != TX_IDLE);

// bit timer, held at zero while idle
always_ff @(posedge clock) begin
	if (reset_i)
		baud_count <= '0;
	else if (state == TX_IDLE || baud_wrap)
		baud_count <= '0;
	else
		baud_count <= baud_count + 1'b1;
end

always_ff @(posedge clock) begin
	if (reset_i) begin
		state <= TX_IDLE;
		bit_count <= '0;
		tx_o <= 1'b1; // line idles high
	end else begin
		case (state)
		TX_IDLE: begin
			if (write_i) begin
				state <= TX_START;
				tx_o <= 1'b0;
			end
		end
		TX_START: begin
			if (baud_wrap) begin
				state <= TX_DATA;
				bit_count <= '0;
				tx_o <= shift[0];
			end
		end
		TX_DATA: begin
			if (baud_wrap) begin
				if (bit_count == 3'd7) begin
					state <= TX_STOP;
					tx_o <= 1'b1;
				end else begin
					bit_count <= bit_count + 1'b1;
					tx_o <= shift[0];
				end
			end
		end
		TX_STOP: begin
			if (baud_wrap)
				state <= TX_IDLE;
		end
		default: state <= TX_IDLE;
		endcase
	end
end

// lsb first, next bit always sits in shift[0]
always_ff @(posedge clock) begin
	if (state == TX_IDLE && write_i)
		shift <= data_i;
	else if (baud_wrap && (state == TX_START || state == TX_DATA))
		shift <= shift >> 1;
end

endmodule

// File: tb/tb_bringup.sv
// bringup testbench with random pin activity checked against the uart reports of the DUT
module tb_bringup;

timeunit 1ns;
timeprecision 100ps;

localparam int PINS = 16;
localparam int LOOP_PIN = 5;
localparam int CLOCKS_PER_BAUD = 8;
localparam int CLOCKS_PER_SCAN = 2000;
localparam int CLOCKS_PER_DRIVE = 50;
localparam int HALF_PERIOD = 5;
localparam int WINDOWS = 10; // quiet, eight random, quiet
localparam int REPORT_LEN = PINS + 2;
localparam int FRAME_BITS = 10;
localparam int CHANGE_FIRST = 20;
localparam int CHANGE_LAST = 1900;
localparam int DRIVE_EDGES = 6;
localparam int REPORT_GAP = 300; // well short of the next scan
localparam int TIMEOUT_NS = WINDOWS * CLOCKS_PER_SCAN * 2 * HALF_PERIOD * 12 / 10;
localparam logic [PINS-1:0] LOOP_MASK = PINS'(1) << LOOP_PIN;
localparam logic [7:0] CHAR_ACTIVE = 8'h31; // "1"
localparam logic [7:0] CHAR_QUIET = 8'h30;
localparam logic [7:0] CHAR_CR = 8'h0d;
localparam logic [7:0] CHAR_LF = 8'h0a;

logic clock;
logic reset_i;
logic [PINS-1:0] drive_pins;
logic [PINS-1:0] pins;
logic tp9;
logic uart_tx;

// activity model with one vector per scan window
logic [PINS-1:0] expected_act [WINDOWS];
logic [7:0] rx_bytes [$];
int frame_errs = 0;
int tests_passed = 0;
int tests_failed = 0;

bringup_boundary #(
	.CLOCKS_PER_BAUD(CLOCKS_PER_BAUD),
	.CLOCKS_PER_SCAN(CLOCKS_PER_SCAN),
	.CLOCKS_PER_DRIVE(CLOCKS_PER_DRIVE)
) UUT(
	.clock(clock),
	.reset_i(reset_i),
	.pins_i(pins),
	.tp9_o(tp9),
	.uart_tx_o(uart_tx));

always #HALF_PERIOD clock = ~clock;

always_comb begin
	pins = drive_pins;
	pins[LOOP_PIN] = tp9; // drive pin looped back
end

task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual, inout int errs);
	if (actual !== expected) begin
		$display("Error: %s expected %0h actual %0h", name, expected, actual);
		errs++;
	end
endtask

task automatic finish_test(input string name, input int errs);
	if (errs == 0) begin
		$display("%s: pass", name);
		tests_passed++;
	end else begin
		$display("%s: fail, %0d mismatches", name, errs);
		tests_failed++;
	end
endtask

task automatic check_reset_state();
	int errs;
	int n;
	errs = 0;
	n = 0;
	@(negedge clock);
	check("reset tp9 level", 0, tp9, errs);
	check("reset uart idle", 1, uart_tx, errs);
	while (uart_tx === 1'b1 && n < CLOCKS_PER_SCAN + 20) begin
		@(negedge clock);
		n++;
	end
	// scan pulse, then the snapshot edge, then the write that starts the frame
	check("first start bit cycle", CLOCKS_PER_SCAN + 2, n, errs);
	finish_test("reset state", errs);
endtask

task automatic check_drive_period();
	int errs;
	int n;
	int prev;
	logic last;
	errs = 0;
	n = 0;
	prev = 0;
	@(negedge clock);
	last = tp9;
	for (int e = 0; e < DRIVE_EDGES; e++) begin
		while (tp9 === last && n < prev + 2 * CLOCKS_PER_DRIVE) begin
			@(negedge clock);
			n++;
		end
		check($sformatf("tp9 edge %0d spacing", e), CLOCKS_PER_DRIVE, n - prev, errs);
		last = tp9;
		prev = n;
	end
	finish_test("drive period", errs);
endtask

task automatic drive_windows();
	logic [PINS-1:0] subset;
	logic [PINS-1:0] toggles;
	for (int w = 0; w < WINDOWS; w++) begin
		expected_act[w] = LOOP_MASK; // tp9 moves in every window
		subset = PINS'($urandom) & ~LOOP_MASK;
		for (int k = 1; k <= CLOCKS_PER_SCAN; k++) begin
			@(posedge clock);
			// first and last windows stay quiet
			if (w > 0 && w < WINDOWS - 1 && k >= CHANGE_FIRST && k <= CHANGE_LAST
					&& $urandom_range(255) == 0) begin
				toggles = PINS'($urandom) & subset;
				drive_pins <= drive_pins ^ toggles;
				expected_act[w] = expected_act[w] | toggles;
			end
		end
	end
endtask

task automatic check_reports();
	int rand_errs;
	int quiet_errs;
	logic [7:0] got;
	logic [7:0] want;
	rand_errs = 0;
	quiet_errs = 0;
	for (int r = 0; r < WINDOWS; r++) begin
		while (rx_bytes.size() < REPORT_LEN)
			@(negedge clock);
		for (int i = 0; i < PINS; i++) begin
			got = rx_bytes.pop_front();
			want = expected_act[r][i] ? CHAR_ACTIVE : CHAR_QUIET;
			if (r == 0 || r == WINDOWS - 1)
				check($sformatf("quiet report %0d pin %0d", r, i), want, got, quiet_errs);
			else
				check($sformatf("random report %0d pin %0d", r, i), want, got, rand_errs);
		end
		got = rx_bytes.pop_front();
		check($sformatf("report %0d cr", r), CHAR_CR, got, frame_errs);
		got = rx_bytes.pop_front();
		check($sformatf("report %0d lf", r), CHAR_LF, got, frame_errs);
		// nothing else before the next scan
		repeat (REPORT_GAP) @(negedge clock);
		check($sformatf("report %0d extra bytes", r), 0, rx_bytes.size(), frame_errs);
		if (r == WINDOWS - 2)
			finish_test("random windows", rand_errs);
	end
	finish_test("quiet windows", quiet_errs);
	finish_test("frame format", frame_errs);
endtask

// serial decoder samples every clock of every bit
initial begin : uart_decoder
	logic [FRAME_BITS-1:0] bits;
	wait (reset_i === 1'b0);
	forever begin
		@(negedge uart_tx); // start bit edge
		for (int b = 0; b < FRAME_BITS; b++) begin
			@(negedge clock);
			bits[b] = uart_tx;
			for (int j = 1; j < CLOCKS_PER_BAUD; j++) begin
				@(negedge clock);
				check($sformatf("frame bit %0d width", b), bits[b], uart_tx, frame_errs);
			end
		end
		check("frame stop bit", 1, bits[FRAME_BITS-1], frame_errs);
		rx_bytes.push_back(bits[8:1]); // lsb first on the line
	end
end

initial begin : watchdog
	#(TIMEOUT_NS);
	$display("watchdog: run timed out after %0d ns with reports still missing", TIMEOUT_NS);
	$display("Test FAILED");
	$finish;
end

initial begin
	void'($urandom(87));
	clock = 1'b0;
	reset_i = 1'b1;
	drive_pins = '0;
	repeat (4) @(posedge clock);
	reset_i <= 1'b0;
	fork
		check_reset_state();
		check_drive_period();
		drive_windows();
		check_reports();
	join
	$display("tests passed %0d, failed %0d", tests_passed, tests_failed);
	if (tests_failed == 0 && tests_passed == 5)
		$display("Test OK");
	else
		$display("Test FAILED");
	$finish;
end

endmodule
